// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := write_guard_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run and check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
hw/wg_pkg.sv
hw/wg_slot_table.sv
hw/wg_age_tracker.sv
hw/wg_guard_ctrl.sv
hw/write_guard.sv
tests/write_guard_props.sv
tests/write_guard_tb.sv

// File: hw/wg_age_tracker.sv
////////////////////////////////////////////////////////////
// Per-slot age counters
// Overrun check against budget*16 + length, and oldest
// matching slot selection for retirement
////////////////////////////////////////////////////////////

module wg_age_tracker (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      alloc_i,
  input  wg_pkg::slot_idx_t                         alloc_idx_i,
  input  wg_pkg::slot_mask_t                        slot_valid_i,
  input  wg_pkg::burst_len_t [wg_pkg::MAX_TXNS-1:0] slot_len_i,
  input  wg_pkg::budget_t                           budget_i,
  input  wg_pkg::slot_mask_t                        match_mask_i,
  output wg_pkg::slot_idx_t                         oldest_idx_o,
  output logic                                      overrun_o,
  output wg_pkg::slot_idx_t                         overrun_idx_o
);

  import wg_pkg::*;

  age_cnt_t   age_q [MAX_TXNS];
  age_cnt_t   budget_cycles;
  slot_mask_t over_mask;

  // Budget scaled to cycles
  assign budget_cycles = age_cnt_t'({budget_i, {BUDGET_UNIT_LOG2{1'b0}}});

  // Age counters, saturating at all ones
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MAX_TXNS; i++) begin
        age_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < MAX_TXNS; i++) begin
        if (alloc_i && (alloc_idx_i == slot_idx_t'(i))) begin
          age_q[i] <= '0;
        end else if (slot_valid_i[i] && (age_q[i] != '1)) begin
          age_q[i] <= age_q[i] + 1'b1;
        end
      end
    end
  end

  // Limit compare per valid slot
  always_comb begin
    age_cnt_t limit;
    for (int i = 0; i < MAX_TXNS; i++) begin
      limit        = budget_cycles + age_cnt_t'(slot_len_i[i]);
      over_mask[i] = slot_valid_i[i] && (age_q[i] > limit);
    end
  end

  // Lowest overrunning slot
  always_comb begin
    logic found;
    found         = 1'b0;
    overrun_idx_o = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      if (over_mask[i] && !found) begin
        overrun_idx_o = slot_idx_t'(i);
        found         = 1'b1;
      end
    end
  end

  assign overrun_o = |over_mask;

  // Oldest slot among those matching the B ID
  // Ages of valid slots never tie, so strict compare is enough
  always_comb begin
    logic     found;
    age_cnt_t best_age;
    found        = 1'b0;
    best_age     = '0;
    oldest_idx_o = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      if (match_mask_i[i] && (!found || (age_q[i] > best_age))) begin
        oldest_idx_o = slot_idx_t'(i);
        best_age     = age_q[i];
        found        = 1'b1;
      end
    end
  end

endmodule

// File: hw/wg_guard_ctrl.sv
////////////////////////////////////////////////////////////
// Guard control FSM
// AW gating, alloc/retire/flush strobes, fault capture
// and interrupt pulse
////////////////////////////////////////////////////////////

module wg_guard_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 aw_valid_i,
  input  logic                 aw_ready_i,
  input  logic                 b_valid_i,
  input  logic                 b_ready_i,
  input  wg_pkg::txn_id_t      b_id_i,
  input  logic                 full_i,
  input  wg_pkg::slot_mask_t   match_mask_i,
  input  logic                 overrun_i,
  input  wg_pkg::txn_id_t      overrun_id_i,
  input  logic                 reset_clear_i,
  output logic                 aw_valid_o,
  output logic                 aw_ready_o,
  output logic                 alloc_o,
  output logic                 retire_o,
  output logic                 flush_o,
  output logic                 reset_req_o,
  output logic                 irq_o,
  output wg_pkg::fault_cause_e fault_cause_o,
  output wg_pkg::txn_id_t      fault_id_o
);

  import wg_pkg::*;

  guard_state_e state_q, state_d;
  fault_cause_e fault_cause_q;
  txn_id_t      fault_id_q;
  logic         irq_q;

  logic monitoring;
  logic gate_open;
  logic b_hs;
  logic b_hit;
  logic timeout_fault;
  logic unexp_fault;
  logic fault;

  assign monitoring = (state_q == ST_MONITOR);
  assign gate_open  = monitoring && !full_i;

  // AW pass-through, closed when full or in reset request
  assign aw_valid_o = aw_valid_i && gate_open;
  assign aw_ready_o = aw_ready_i && gate_open;

  assign b_hs  = b_valid_i && b_ready_i;
  assign b_hit = |match_mask_i;

  // Faults only count while monitoring
  assign timeout_fault = monitoring && overrun_i;
  assign unexp_fault   = monitoring && b_hs && !b_hit;
  assign fault         = timeout_fault || unexp_fault;

  assign alloc_o  = aw_valid_i && aw_ready_o;
  assign retire_o = monitoring && b_hs && b_hit;
  assign flush_o  = fault;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_MONITOR: begin
        if (fault) begin
          state_d = ST_RESET_REQ;
        end
      end
      ST_RESET_REQ: begin
        // Held until software acknowledges
        if (reset_clear_i) begin
          state_d = ST_MONITOR;
        end
      end
      default: state_d = ST_MONITOR;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_MONITOR;
      irq_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      irq_q   <= fault;
    end
  end

  // Cause and ID stay until the next fault, timeout first
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fault_cause_q <= FAULT_NONE;
      fault_id_q    <= '0;
    end else if (timeout_fault) begin
      fault_cause_q <= FAULT_TIMEOUT;
      fault_id_q    <= overrun_id_i;
    end else if (unexp_fault) begin
      fault_cause_q <= FAULT_UNEXPECTED_B;
      fault_id_q    <= b_id_i;
    end
  end

  assign reset_req_o   = (state_q == ST_RESET_REQ);
  assign irq_o         = irq_q;
  assign fault_cause_o = fault_cause_q;
  assign fault_id_o    = fault_id_q;

endmodule

// File: hw/wg_pkg.sv
////////////////////////////////////////////////////////////
// Write guard shared definitions
// Sizes, vector types, FSM states and fault causes
////////////////////////////////////////////////////////////

package wg_pkg;

  // AXI field widths
  localparam int unsigned ID_WIDTH  = 4;
  localparam int unsigned LEN_WIDTH = 8;

  // Slot table geometry
  localparam int unsigned MAX_TXNS       = 8;
  localparam int unsigned SLOT_IDX_WIDTH = 3;

  // Age counting, budget is in units of 16 cycles
  localparam int unsigned AGE_WIDTH        = 12;
  localparam int unsigned BUDGET_WIDTH     = 4;
  localparam int unsigned BUDGET_UNIT_LOG2 = 4;

  typedef logic [ID_WIDTH-1:0]       txn_id_t;
  typedef logic [LEN_WIDTH-1:0]      burst_len_t;
  typedef logic [SLOT_IDX_WIDTH-1:0] slot_idx_t;
  typedef logic [MAX_TXNS-1:0]       slot_mask_t;
  typedef logic [AGE_WIDTH-1:0]      age_cnt_t;
  typedef logic [BUDGET_WIDTH-1:0]   budget_t;

  // Guard FSM
  typedef enum logic {
    ST_MONITOR,
    ST_RESET_REQ
  } guard_state_e;

  // Reason for the last reset request
  typedef enum logic [1:0] {
    FAULT_NONE         = 2'd0,
    FAULT_TIMEOUT      = 2'd1,
    FAULT_UNEXPECTED_B = 2'd2
  } fault_cause_e;

endpackage

// File: hw/wg_slot_table.sv
////////////////////////////////////////////////////////////
// Outstanding write slot table
// Valid/ID/length storage, free slot search, B ID match
// and pending count
////////////////////////////////////////////////////////////

module wg_slot_table (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      alloc_i,
  input  logic                                      retire_i,
  input  wg_pkg::slot_idx_t                         retire_idx_i,
  input  logic                                      flush_i,
  input  wg_pkg::txn_id_t                           aw_id_i,
  input  wg_pkg::burst_len_t                        aw_len_i,
  input  wg_pkg::txn_id_t                           b_id_i,
  input  wg_pkg::slot_idx_t                         overrun_idx_i,
  output wg_pkg::slot_idx_t                         free_idx_o,
  output logic                                      full_o,
  output wg_pkg::slot_mask_t                        match_mask_o,
  output wg_pkg::slot_mask_t                        slot_valid_o,
  output wg_pkg::burst_len_t [wg_pkg::MAX_TXNS-1:0] slot_len_o,
  output wg_pkg::txn_id_t                           overrun_id_o,
  output logic [wg_pkg::SLOT_IDX_WIDTH:0]           pending_cnt_o
);

  import wg_pkg::*;

  slot_mask_t                      valid_q;
  txn_id_t                         id_q [MAX_TXNS];
  burst_len_t [MAX_TXNS-1:0]       len_q;

  slot_idx_t                       free_idx;
  logic [SLOT_IDX_WIDTH:0]         pending_cnt;

  // Lowest free slot, only meaningful while not full
  always_comb begin
    logic found;
    found    = 1'b0;
    free_idx = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      if (!valid_q[i] && !found) begin
        free_idx = slot_idx_t'(i);
        found    = 1'b1;
      end
    end
  end

  // B ID compare and occupancy count
  always_comb begin
    pending_cnt = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      match_mask_o[i] = valid_q[i] && (id_q[i] == b_id_i);
      if (valid_q[i]) begin
        pending_cnt = pending_cnt + 1'b1;
      end
    end
  end

  // Flush wins over a same-cycle alloc or retire
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      if (retire_i) begin
        valid_q[retire_idx_i] <= 1'b0;
      end
      if (alloc_i) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  // Burst attributes, written on allocation
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      id_q[free_idx]  <= aw_id_i;
      len_q[free_idx] <= aw_len_i;
    end
  end

  assign free_idx_o    = free_idx;
  assign full_o        = &valid_q;
  assign slot_valid_o  = valid_q;
  assign slot_len_o    = len_q;
  assign overrun_id_o  = id_q[overrun_idx_i];
  assign pending_cnt_o = pending_cnt;

endmodule

// File: hw/write_guard.sv
////////////////////////////////////////////////////////////
// Write guard top level
// Slot table, age tracker and control FSM
////////////////////////////////////////////////////////////

module write_guard (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // AW from master
  input  logic                            aw_valid_i,
  input  wg_pkg::txn_id_t                 aw_id_i,
  input  wg_pkg::burst_len_t              aw_len_i,
  output logic                            aw_ready_o,
  // AW towards slave
  output logic                            aw_valid_o,
  input  logic                            aw_ready_i,
  // Observed B channel
  input  logic                            b_valid_i,
  input  logic                            b_ready_i,
  input  wg_pkg::txn_id_t                 b_id_i,
  // Software control and status
  input  wg_pkg::budget_t                 budget_i,
  input  logic                            reset_clear_i,
  output logic                            reset_req_o,
  output logic                            irq_o,
  output wg_pkg::fault_cause_e            fault_cause_o,
  output wg_pkg::txn_id_t                 fault_id_o,
  output logic [wg_pkg::SLOT_IDX_WIDTH:0] pending_cnt_o
);

  import wg_pkg::*;

  logic                      alloc;
  logic                      retire;
  logic                      flush;
  logic                      full;
  logic                      overrun;
  slot_idx_t                 free_idx;
  slot_idx_t                 oldest_idx;
  slot_idx_t                 overrun_idx;
  slot_mask_t                match_mask;
  slot_mask_t                slot_valid;
  burst_len_t [MAX_TXNS-1:0] slot_len;
  txn_id_t                   overrun_id;

  wg_slot_table u_slot_table (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .alloc_i       (alloc),
    .retire_i      (retire),
    .retire_idx_i  (oldest_idx),
    .flush_i       (flush),
    .aw_id_i       (aw_id_i),
    .aw_len_i      (aw_len_i),
    .b_id_i        (b_id_i),
    .overrun_idx_i (overrun_idx),
    .free_idx_o    (free_idx),
    .full_o        (full),
    .match_mask_o  (match_mask),
    .slot_valid_o  (slot_valid),
    .slot_len_o    (slot_len),
    .overrun_id_o  (overrun_id),
    .pending_cnt_o (pending_cnt_o)
  );

  wg_age_tracker u_age_tracker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .alloc_i       (alloc),
    .alloc_idx_i   (free_idx),
    .slot_valid_i  (slot_valid),
    .slot_len_i    (slot_len),
    .budget_i      (budget_i),
    .match_mask_i  (match_mask),
    .oldest_idx_o  (oldest_idx),
    .overrun_o     (overrun),
    .overrun_idx_o (overrun_idx)
  );

  wg_guard_ctrl u_guard_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_i    (aw_ready_i),
    .b_valid_i     (b_valid_i),
    .b_ready_i     (b_ready_i),
    .b_id_i        (b_id_i),
    .full_i        (full),
    .match_mask_i  (match_mask),
    .overrun_i     (overrun),
    .overrun_id_i  (overrun_id),
    .reset_clear_i (reset_clear_i),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_o    (aw_ready_o),
    .alloc_o       (alloc),
    .retire_o      (retire),
    .flush_o       (flush),
    .reset_req_o   (reset_req_o),
    .irq_o         (irq_o),
    .fault_cause_o (fault_cause_o),
    .fault_id_o    (fault_id_o)
  );

endmodule

// File: tests/write_guard_input.txt
# Each line holds a command and up to two decimal arguments
# TEST name, BUDGET b, AW id len, B id, IDLE n, CLEAR, FULLFILL, CHECK field expected
TEST oldest_first
BUDGET 1
AW 3 0
AW 3 40
B 3
CHECK PENDING 1
IDLE 30
CHECK REQ 0
B 3
CHECK PENDING 0
TEST timeout
AW 5 2
IDLE 19
CHECK REQ 0
IDLE 1
CHECK REQ 1
CHECK IRQ 1
CHECK CAUSE 1
CHECK FID 5
CHECK PENDING 0
IDLE 1
CHECK IRQ 0
CLEAR
TEST budget_scaling
BUDGET 2
AW 1 5
IDLE 36
B 1
CHECK REQ 0
CHECK PENDING 0
BUDGET 0
AW 2 9
IDLE 9
B 2
CHECK REQ 1
CHECK FID 2
CLEAR
TEST full_table
BUDGET 15
FULLFILL
CHECK PENDING 8
CHECK GATE 0
TEST unexpected_b
B 12
CHECK CAUSE 2
CHECK FID 12
CHECK GATE 0
CLEAR
CHECK REQ 0
AW 4 0
CHECK PENDING 1
CHECK CAUSE 2

// File: tests/write_guard_props.sv
////////////////////////////////////////////////////////////
// Write guard assertions, bound into write_guard
////////////////////////////////////////////////////////////

module write_guard_props (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            irq_o,
  input logic                            reset_req_o,
  input logic                            aw_valid_o,
  input logic                            aw_ready_o,
  input logic [wg_pkg::SLOT_IDX_WIDTH:0] pending_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // Interrupt is a single cycle pulse
  irq_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) irq_o |=> !irq_o)
    else begin
      fail_cnt++;
      $error("irq_o stayed high for more than one cycle");
    end

  // AW stays closed during a reset request
  aw_blocked_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reset_req_o |-> (!aw_ready_o && !aw_valid_o))
    else begin
      fail_cnt++;
      $error("AW channel open while reset_req_o is high");
    end

  // A fault empties the table by the interrupt cycle
  flush_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o |-> (pending_cnt_o == '0))
    else begin
      fail_cnt++;
      $error("pending_cnt_o not zero in the interrupt cycle");
    end

endmodule

bind write_guard write_guard_props u_props (.*);

// File: tests/write_guard_tb.sv
////////////////////////////////////////////////////////////
// Write guard testbench
// Clock, reset, file driven commands, value checks,
// watchdog and closing summary
////////////////////////////////////////////////////////////

module write_guard_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import wg_pkg::*;

  localparam string STIM_FILE       = "tests/write_guard_input.txt";
  localparam int    CYCLES_PER_LINE = 200;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    aw_valid_i;
  txn_id_t                 aw_id_i;
  burst_len_t              aw_len_i;
  logic                    aw_ready_o;
  logic                    aw_valid_o;
  logic                    aw_ready_i;
  logic                    b_valid_i;
  logic                    b_ready_i;
  txn_id_t                 b_id_i;
  budget_t                 budget_i;
  logic                    reset_clear_i;
  logic                    reset_req_o;
  logic                    irq_o;
  fault_cause_e            fault_cause_o;
  txn_id_t                 fault_id_o;
  logic [SLOT_IDX_WIDTH:0] pending_cnt_o;

  int    errors;
  int    checks;
  int    seed;
  int    watchdog_cycles;
  string test_name;

  write_guard u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("Mismatch in %s: expected %0d, actual %0d", what, expected, actual);
    end
  endtask

  // Master holds AW valid, slave stalls 0 to 3 cycles
  task automatic send_aw(input int id, input int len);
    int   stall;
    int   waited;
    logic accepted;
    logic fwd_valid;
    stall      = $unsigned($random(seed)) % 4;
    aw_valid_i = 1'b1;
    aw_id_i    = txn_id_t'(id);
    aw_len_i   = burst_len_t'(len);
    aw_ready_i = 1'b0;
    repeat (stall) next_cycle();
    aw_ready_i = 1'b1;
    accepted   = 1'b0;
    fwd_valid  = 1'b0;
    waited     = 0;
    while (!accepted && waited < 16) begin
      #1;
      accepted  = aw_ready_o;
      fwd_valid = aw_valid_o;
      next_cycle();
      waited++;
    end
    aw_valid_i = 1'b0;
    aw_ready_i = 1'b0;
    if (!accepted) begin
      errors++;
      $display("Error in %s: AW with ID %0d was never accepted", test_name, id);
    end else begin
      // Slave side sees the burst in the accepting cycle
      check_value({test_name, "/AW_VALID"}, 1, int'(fwd_valid));
    end
  endtask

  // B ready follows valid one cycle later
  task automatic send_b(input int id);
    b_valid_i = 1'b1;
    b_ready_i = 1'b0;
    b_id_i    = txn_id_t'(id);
    next_cycle();
    b_ready_i = 1'b1;
    next_cycle();
    b_valid_i = 1'b0;
    b_ready_i = 1'b0;
  endtask

  task automatic clear_fault();
    reset_clear_i = 1'b1;
    next_cycle();
    reset_clear_i = 1'b0;
  endtask

  task automatic fill_table();
    for (int i = 0; i < MAX_TXNS; i++) begin
      send_aw(i, 0);
    end
  endtask

  // GATE offers AW from both sides for one cycle
  task automatic check_field(input string field, input int expected);
    string what;
    what = {test_name, "/", field};
    case (field)
      "PENDING": check_value(what, expected, int'(pending_cnt_o));
      "REQ":     check_value(what, expected, int'(reset_req_o));
      "IRQ":     check_value(what, expected, int'(irq_o));
      "CAUSE":   check_value(what, expected, int'(fault_cause_o));
      "FID":     check_value(what, expected, int'(fault_id_o));
      "GATE": begin
        aw_valid_i = 1'b1;
        aw_ready_i = 1'b1;
        #1;
        check_value({what, "/VALID"}, expected, int'(aw_valid_o));
        check_value({what, "/READY"}, expected, int'(aw_ready_o));
        next_cycle();
        aw_valid_i = 1'b0;
        aw_ready_i = 1'b0;
      end
      default: begin
        errors++;
        $display("Error in %s: unknown field %s in a CHECK line", test_name, field);
      end
    endcase
  endtask

  task automatic count_lines(output int n);
    int               fd;
    logic [8*128-1:0] line;
    n  = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        n++;
      end
      $fclose(fd);
    end
  endtask

  task automatic run_commands(input int fd);
    logic [8*32-1:0]  tok;
    logic [8*128-1:0] rest;
    int               a1;
    int               a2;
    int               code;
    while ($fscanf(fd, "%s", tok) == 1) begin
      case (string'(tok))
        "#":        code = $fgets(rest, fd);
        "TEST": begin
          code      = $fscanf(fd, "%s", tok);
          test_name = string'(tok);
        end
        "BUDGET": begin
          code     = $fscanf(fd, "%d", a1);
          budget_i = budget_t'(a1);
        end
        "AW": begin
          code = $fscanf(fd, "%d %d", a1, a2);
          send_aw(a1, a2);
        end
        "B": begin
          code = $fscanf(fd, "%d", a1);
          send_b(a1);
        end
        "IDLE": begin
          code = $fscanf(fd, "%d", a1);
          repeat (a1) next_cycle();
        end
        "CLEAR":    clear_fault();
        "FULLFILL": fill_table();
        "CHECK": begin
          code = $fscanf(fd, "%s %d", tok, a1);
          check_field(string'(tok), a1);
        end
        default: begin
          errors++;
          $display("Error: unknown command %s in the stimulus file", string'(tok));
        end
      endcase
    end
  endtask

  initial begin
    int fd;
    int n_lines;
    rst_n_i       = 1'b0;
    aw_valid_i    = 1'b0;
    aw_id_i       = '0;
    aw_len_i      = '0;
    aw_ready_i    = 1'b0;
    b_valid_i     = 1'b0;
    b_ready_i     = 1'b0;
    b_id_i        = '0;
    budget_i      = '0;
    reset_clear_i = 1'b0;
    seed          = 50;
    errors        = 0;
    checks        = 0;
    test_name     = "setup";
    count_lines(n_lines);
    watchdog_cycles = (n_lines + 1) * CYCLES_PER_LINE;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("Error: could not open the stimulus file %s", STIM_FILE);
    end else begin
      run_commands(fd);
      $fclose(fd);
    end
    errors += u_dut.u_props.fail_cnt;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget scales with the number of command lines
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Error: the run timed out after %0d cycles", watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule
